// ==== ifmap_decompressor.f ====
+incdir+rtl
rtl/decomp_pkg.sv
rtl/group_fetch_buffer.sv
rtl/unit_unpacker.sv
rtl/run_length_expander.sv
rtl/packet_assembler.sv
rtl/ifmap_decompressor.sv
testbench/tb_ifmap_decompressor.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/100ps -f ifmap_decompressor.f \
    --top-module tb_ifmap_decompressor -Mdir obj_dir -o tb_ifmap_decompressor \
    > build.log 2>&1 &&
./obj_dir/tb_ifmap_decompressor > sim.log 2>&1 ||
{ echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -q "TESTS PASSED" sim.log && echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }

// ==== testbench/tb_ifmap_decompressor.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "decomp_defs.svh"

module tb_ifmap_decompressor;

    // one group expands to at most 80 bytes and a byte costs at most about four cycles
    // once unit bubbles and a half-ready consumer are counted, plus slack for reset and latency
    localparam int TOTAL_GROUPS    = 44;
    localparam int MAX_GROUP_BYTES = `DECOMP_UNITS_PER_GROUP * 16;
    localparam int TIMEOUT_CYCLES  = TOTAL_GROUPS * MAX_GROUP_BYTES * 4 + 2000;
    localparam int MAX_MAP_GROUPS  = 32;
    localparam int REQ_LIMIT       = `DECOMP_FIFO_DEPTH + 3; // fifo plus groups drained into one packet

    logic                  layer23_gated_clk = 1'b0;
    logic                  rst_n;
    logic                  start;
    logic                  mem_ack;
    decomp_pkg::group_t    mem_data = '0;
    logic                  mem_data_valid = 1'b0;
    logic                  ifmap_buffer_req = 1'b0;
    logic                  mem_req;
    logic                  packet_valid;
    decomp_pkg::pkt_data_t packet_data;
    decomp_pkg::pkt_mask_t valid_mask;

    decomp_pkg::group_t    map_mem [MAX_MAP_GROUPS];  // groups of the map under test
    int                    map_len = 0;
    int                    mem_latency = 2;           // cycles from grant to returned word
    int                    ready_mode = 0;            // 0 always ready, 1 random, 2 held off
    decomp_pkg::elem_t     exp_q [$];                 // reference byte stream
    int                    ret_due [$];
    int                    ret_idx [$];
    int                    issue_cnt = 0;
    int                    rx_cnt = 0;
    decomp_pkg::elem_t     last_rx = '0;
    int                    cyc = 0;
    int                    err_cnt = 0;
    int                    chk_cnt = 0;
    logic [31:0]           rng_state = 32'd32;
    logic                  nxt_valid = 1'b0;
    decomp_pkg::group_t    nxt_data = '0;
    logic                  nxt_req = 1'b0;
    logic                  prev_pending = 1'b0;       // packet shown and not taken last cycle
    decomp_pkg::pkt_data_t prev_data = '0;
    decomp_pkg::pkt_mask_t prev_mask = '0;

    ifmap_decompressor dut_i (
        .layer23_gated_clk (layer23_gated_clk),
        .rst_n             (rst_n),
        .start             (start),
        .mem_ack           (mem_ack),
        .mem_data          (mem_data),
        .mem_data_valid    (mem_data_valid),
        .ifmap_buffer_req  (ifmap_buffer_req),
        .mem_req           (mem_req),
        .packet_valid      (packet_valid),
        .packet_data       (packet_data),
        .valid_mask        (valid_mask)
    );

    always #50 layer23_gated_clk = ~layer23_gated_clk;

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                   input logic [63:0] got_v);
        $display("error: %s expected %0h got %0h", name, exp_v, got_v);
        err_cnt = err_cnt + 1;
    endtask

    // inputs change only a little after the rising edge, from values chosen at the negedge
    always @(posedge layer23_gated_clk) begin
        #1;
        mem_data_valid   = nxt_valid;
        mem_data         = nxt_data;
        ifmap_buffer_req = nxt_req;
    end

    // the negedge sees settled outputs, which are the values the next rising edge acts on
    always @(negedge layer23_gated_clk) begin : monitor_blk
        logic [31:0]           r;
        int                    idx;
        int                    remaining;
        decomp_pkg::pkt_mask_t exp_mask;
        cyc = cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("summary: %0d checks, %0d errors", chk_cnt, err_cnt);
            $display("TESTS FAILED");
            $finish;
        end else begin
            if (start) begin
                issue_cnt = 0;   // new map, request numbering restarts at group 0
                rx_cnt    = 0;
            end
            if (mem_req && mem_ack) begin
                ret_due.push_back(cyc + mem_latency);
                ret_idx.push_back(issue_cnt);
                issue_cnt = issue_cnt + 1;
            end
            // memory answers in issue order, one word per cycle at most
            nxt_valid = 1'b0;
            if (ret_due.size() != 0 && ret_due[0] <= cyc) begin
                idx = ret_idx.pop_front();
                void'(ret_due.pop_front());
                nxt_valid = 1'b1;
                // words past the map carry end index 7 and the request number
                nxt_data  = (idx < map_len) ? map_mem[idx] : {4'h7, 28'h0, idx};
            end
            case (ready_mode)
                0: nxt_req = 1'b1;
                1: begin
                    r       = next_rand();
                    nxt_req = r[3];
                end
                default: nxt_req = 1'b0;
            endcase
            if (prev_pending) begin
                chk_cnt = chk_cnt + 1;
                if (!packet_valid) begin
                    $display("error: packet_valid dropped while the packet was still untaken");
                    err_cnt = err_cnt + 1;
                end
                if (packet_data != prev_data) begin
                    report_mismatch("packet_data (held)", prev_data, packet_data);
                end
                if (valid_mask != prev_mask) begin
                    report_mismatch("valid_mask (held)", 64'(prev_mask), 64'(valid_mask));
                end
            end
            if (packet_valid && ifmap_buffer_req) begin
                remaining = exp_q.size() - rx_cnt;
                chk_cnt   = chk_cnt + 1;
                if (remaining <= 0) begin
                    $display("error: a packet was transferred after the whole map had arrived");
                    err_cnt = err_cnt + 1;
                end else begin
                    // full packets carry all slots, the closing one only its low bytes
                    exp_mask = (remaining >= 8) ? 8'hff : 8'((1 << remaining) - 1);
                    if (valid_mask != exp_mask) begin
                        report_mismatch("valid_mask", 64'(exp_mask), 64'(valid_mask));
                    end
                    for (int s = 0; s < `DECOMP_PKT_SLOTS; s++) begin
                        if (exp_mask[s] && rx_cnt < exp_q.size()) begin
                            if (packet_data[s*8 +: 8] != exp_q[rx_cnt]) begin
                                report_mismatch($sformatf("packet_data[%0d]", s),
                                                64'(exp_q[rx_cnt]), 64'(packet_data[s*8 +: 8]));
                            end
                            last_rx = packet_data[s*8 +: 8];
                            rx_cnt  = rx_cnt + 1;
                        end
                    end
                end
            end
            prev_pending = packet_valid && !ifmap_buffer_req;
            prev_data    = packet_data;
            prev_mask    = valid_mask;
        end
    end

    // random units, end index and flag only in the closing group
    task automatic build_random_map(input int n_groups, input int max_zero, input int end_idx,
                                    input logic end_flag);
        decomp_pkg::group_t word;
        logic [31:0]        r;
        logic [3:0]         zeros;
        for (int g = 0; g < n_groups; g++) begin
            word = '0;
            for (int u = 0; u < `DECOMP_UNITS_PER_GROUP; u++) begin
                r     = next_rand();
                zeros = 4'(r[15:0] % (max_zero + 1));
                word[u*`DECOMP_UNIT_W +: `DECOMP_UNIT_W] = {r[23:16], zeros};
            end
            if (g == n_groups - 1) begin
                word[`DECOMP_END_IDX_LSB +: 3] = 3'(end_idx);
                word[`DECOMP_END_FLAG_BIT]     = end_flag;
                // with the value dropped the final zero is what closes the last packet
                if (!end_flag && word[end_idx*`DECOMP_UNIT_W +: 4] == 4'h0) begin
                    word[end_idx*`DECOMP_UNIT_W +: 4] = 4'h1;
                end
            end else begin
                word[`DECOMP_END_IDX_LSB +: 3] = 3'd7;
                word[`DECOMP_END_FLAG_BIT]     = r[31]; // flag only matters in the end group
            end
            map_mem[g] = word;
        end
        map_len = n_groups;
    endtask

    // reference expansion: zeros then the value, the end unit drops its value on flag 0
    task automatic build_expected();
        decomp_pkg::group_t word;
        logic [2:0]         end_idx;
        logic [3:0]         zeros;
        logic [7:0]         val;
        logic               at_end;
        int                 last_u;
        exp_q.delete();
        at_end = 1'b0;
        for (int g = 0; g < map_len && !at_end; g++) begin
            word    = map_mem[g];
            end_idx = word[`DECOMP_END_IDX_LSB +: 3];
            at_end  = (end_idx != `DECOMP_END_IDX_NONE);
            last_u  = at_end ? int'(end_idx) : `DECOMP_UNITS_PER_GROUP - 1;
            for (int u = 0; u <= last_u; u++) begin
                zeros = word[u*`DECOMP_UNIT_W +: 4];
                val   = word[u*`DECOMP_UNIT_W + 4 +: 8];
                for (int z = 0; z < int'(zeros); z++) begin
                    exp_q.push_back(8'h00);
                end
                if (!(at_end && u == last_u && !word[`DECOMP_END_FLAG_BIT])) begin
                    exp_q.push_back(val);
                end
            end
        end
    endtask

    task automatic begin_map();
        while (ret_due.size() != 0) begin
            @(posedge layer23_gated_clk);   // stale returns would land in the new map
        end
        @(posedge layer23_gated_clk);
        #1 start = 1'b1;
        @(posedge layer23_gated_clk);
        #1 start = 1'b0;
    endtask

    task automatic wait_map_done();
        while (rx_cnt < exp_q.size()) begin
            @(posedge layer23_gated_clk);
        end
        repeat (8) @(posedge layer23_gated_clk); // a stray extra packet would show up here
    endtask

    task automatic test_idle_outputs();
        repeat (3) @(negedge layer23_gated_clk);
        chk_cnt = chk_cnt + 1;
        if (mem_req !== 1'b0) report_mismatch("mem_req", 64'h0, 64'(mem_req));
        if (packet_valid !== 1'b0) report_mismatch("packet_valid", 64'h0, 64'(packet_valid));
    endtask

    task automatic test_single_group();
        ready_mode  = 0;
        mem_latency = 2;
        build_random_map(1, 15, 4, 1'b1);
        build_expected();
        begin_map();
        wait_map_done();
    endtask

    task automatic test_multi_group();
        ready_mode  = 0;
        mem_latency = 4;
        build_random_map(6, 15, 2, 1'b1);
        build_expected();
        if (exp_q.size() % 8 == 0) begin
            map_mem[0][3:0] = map_mem[0][3:0] ^ 4'h1; // one byte more or less
            build_expected();
        end
        begin_map();
        wait_map_done();
    endtask

    task automatic test_back_pressure();
        ready_mode  = 1;
        mem_latency = 2;
        build_random_map(8, 7, 3, 1'b1);
        build_expected();
        begin_map();
        wait_map_done();
    endtask

    task automatic test_end_flag_and_credit();
        int quiet;
        ready_mode  = 0;
        mem_latency = 2;
        build_random_map(2, 5, 1, 1'b0);
        build_expected();
        begin_map();
        wait_map_done();
        chk_cnt = chk_cnt + 1;
        if (last_rx != 8'h00) report_mismatch("packet_data last byte", 64'h0, 64'(last_rx));
        // long map against a stalled consumer, fetching has to stop on credit
        ready_mode  = 2;
        mem_latency = 3;
        build_random_map(24, 1, 4, 1'b1);
        build_expected();
        begin_map();
        quiet = 0;
        while (quiet < 32) begin
            @(negedge layer23_gated_clk);
            quiet = mem_req ? 0 : quiet + 1;
        end
        @(posedge layer23_gated_clk);
        chk_cnt = chk_cnt + 1;
        if (issue_cnt > REQ_LIMIT) begin
            $display("error: %0d requests issued while stalled, at most %0d allowed",
                     issue_cnt, REQ_LIMIT);
            err_cnt = err_cnt + 1;
        end
        ready_mode = 0;
        wait_map_done();
        // a fresh map after the second start
        build_random_map(3, 9, 0, 1'b1);
        build_expected();
        begin_map();
        wait_map_done();
    endtask

    initial begin
        rst_n   = 1'b0;
        start   = 1'b0;
        mem_ack = 1'b0;
        repeat (4) @(posedge layer23_gated_clk);
        #1 rst_n = 1'b1;
        mem_ack = 1'b1;   // memory grants every request
        test_idle_outputs();
        test_single_group();
        test_multi_group();
        test_back_pressure();
        test_end_flag_and_credit();
        $display("summary: %0d checks, %0d errors", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/ifmap_decompressor.sv ====
`timescale 1ns/100ps
`default_nettype none

module ifmap_decompressor (
    input  wire logic               layer23_gated_clk,
    input  wire logic               rst_n,
    input  wire logic               start,
    input  wire logic               mem_ack,
    input  wire decomp_pkg::group_t mem_data,
    input  wire logic               mem_data_valid,
    input  wire logic               ifmap_buffer_req,
    output logic                    mem_req,
    output logic                    packet_valid,
    output decomp_pkg::pkt_data_t   packet_data,
    output decomp_pkg::pkt_mask_t   valid_mask
);

    // fetch buffer to unpacker
    logic                  group_avail;
    logic                  group_pop;
    decomp_pkg::group_t    group;
    // unpacker to expander
    logic                  unit_avail;
    logic                  unit_take;
    decomp_pkg::unit_t     unit;
    logic                  unit_last;
    logic                  keep_last_val;
    // expander to assembler
    logic                  elem_strobe;
    logic                  elem_ready;
    decomp_pkg::elem_t     elem;
    logic                  elem_last;

    group_fetch_buffer fetch_i (
        .layer23_gated_clk (layer23_gated_clk),
        .rst_n             (rst_n),
        .start             (start),
        .mem_ack           (mem_ack),
        .mem_data_valid    (mem_data_valid),
        .mem_data          (mem_data),
        .group_pop         (group_pop),
        .mem_req           (mem_req),
        .group_avail       (group_avail),
        .group             (group)
    );

    unit_unpacker unpack_i (
        .layer23_gated_clk (layer23_gated_clk),
        .rst_n             (rst_n),
        .start             (start),
        .group_avail       (group_avail),
        .group             (group),
        .unit_take         (unit_take),
        .group_pop         (group_pop),
        .unit_avail        (unit_avail),
        .unit              (unit),
        .unit_last         (unit_last),
        .keep_last_val     (keep_last_val)
    );

    run_length_expander expand_i (
        .layer23_gated_clk (layer23_gated_clk),
        .rst_n             (rst_n),
        .start             (start),
        .unit_avail        (unit_avail),
        .unit              (unit),
        .unit_last         (unit_last),
        .keep_last_val     (keep_last_val),
        .elem_ready        (elem_ready),
        .unit_take         (unit_take),
        .elem_strobe       (elem_strobe),
        .elem              (elem),
        .elem_last         (elem_last)
    );

    packet_assembler assemble_i (
        .layer23_gated_clk (layer23_gated_clk),
        .rst_n             (rst_n),
        .start             (start),
        .elem_strobe       (elem_strobe),
        .elem              (elem),
        .elem_last         (elem_last),
        .ifmap_buffer_req  (ifmap_buffer_req),
        .elem_ready        (elem_ready),
        .packet_valid      (packet_valid),
        .packet_data       (packet_data),
        .valid_mask        (valid_mask)
    );

endmodule

`default_nettype wire

// ==== rtl/packet_assembler.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "decomp_defs.svh"

module packet_assembler (
    input  wire logic              layer23_gated_clk,
    input  wire logic              rst_n,
    input  wire logic              start,
    input  wire logic              elem_strobe,
    input  wire decomp_pkg::elem_t elem,
    input  wire logic              elem_last,
    input  wire logic              ifmap_buffer_req,  // global buffer ready to take a packet
    output logic                   elem_ready,
    output logic                   packet_valid,
    output decomp_pkg::pkt_data_t  packet_data,
    output decomp_pkg::pkt_mask_t  valid_mask
);

    localparam int SLOT_W = $clog2(`DECOMP_PKT_SLOTS);

    logic [SLOT_W-1:0] slot_idx;   // next slot to fill
    logic              pkt_done;
    logic              xfer;

    // one packet in flight, so filling waits while a packet is presented
    assign elem_ready = ~packet_valid;
    assign xfer       = packet_valid & ifmap_buffer_req;

    // close on the eighth byte or on the map's last byte
    assign pkt_done = elem_strobe &
                      (elem_last | (slot_idx == SLOT_W'(`DECOMP_PKT_SLOTS - 1)));

    always_ff @(posedge layer23_gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            packet_valid <= 1'b0;
            valid_mask   <= '0;
            slot_idx     <= '0;
        end else if (start) begin
            packet_valid <= 1'b0;
            valid_mask   <= '0;
            slot_idx     <= '0;
        end else if (xfer) begin
            packet_valid <= 1'b0;  // taken, start a fresh packet
            valid_mask   <= '0;
            slot_idx     <= '0;
        end else if (elem_strobe) begin
            valid_mask[slot_idx] <= 1'b1;
            slot_idx             <= slot_idx + 1'b1;
            if (pkt_done) begin
                packet_valid <= 1'b1;  // held stable until the transfer edge
            end
        end
    end

    // slot bytes, only the masked ones are meaningful
    always_ff @(posedge layer23_gated_clk) begin
        if (elem_strobe) begin
            packet_data[slot_idx*`DECOMP_ELEM_W +: `DECOMP_ELEM_W] <= elem;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/run_length_expander.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "decomp_defs.svh"

module run_length_expander (
    input  wire logic              layer23_gated_clk,
    input  wire logic              rst_n,
    input  wire logic              start,
    input  wire logic              unit_avail,
    input  wire decomp_pkg::unit_t unit,
    input  wire logic              unit_last,
    input  wire logic              keep_last_val,
    input  wire logic              elem_ready,     // assembler has a free slot
    output logic                   unit_take,
    output logic                   elem_strobe,
    output decomp_pkg::elem_t      elem,
    output logic                   elem_last       // qualified by elem_strobe
);

    decomp_pkg::expand_state_t state;
    decomp_pkg::zero_run_t     zero_cnt;    // zeros still to emit
    decomp_pkg::zero_run_t     unit_zeros;
    decomp_pkg::elem_t         unit_val;
    decomp_pkg::elem_t         val_reg;
    logic                      last_reg;    // unit being expanded ends the map
    logic                      keep_reg;
    logic                      emit_val;

    assign unit_zeros = unit[`DECOMP_ZERO_W-1:0];
    assign unit_val   = unit[`DECOMP_UNIT_W-1:`DECOMP_ZERO_W];

    // the final unit drops its value byte when the end flag is 0
    assign emit_val = ~last_reg | keep_reg;

    assign unit_take   = (state == decomp_pkg::EXP_IDLE) & unit_avail;
    assign elem_strobe = elem_ready &
                         ((state == decomp_pkg::EXP_ZEROS) | (state == decomp_pkg::EXP_VALUE));
    assign elem        = (state == decomp_pkg::EXP_VALUE) ? val_reg : '0;

    // last byte is either the value or, with no value, the final zero
    assign elem_last = elem_strobe &
        (((state == decomp_pkg::EXP_VALUE) & last_reg) |
         ((state == decomp_pkg::EXP_ZEROS) & (zero_cnt == decomp_pkg::zero_run_t'(1)) & ~emit_val));

    always_ff @(posedge layer23_gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= decomp_pkg::EXP_IDLE;
            zero_cnt <= '0;
            last_reg <= 1'b0;
            keep_reg <= 1'b0;
        end else if (start) begin
            state    <= decomp_pkg::EXP_IDLE;
            zero_cnt <= '0;
            last_reg <= 1'b0;
            keep_reg <= 1'b0;
        end else begin
            case (state)
                decomp_pkg::EXP_IDLE: begin
                    if (unit_avail) begin
                        zero_cnt <= unit_zeros;
                        last_reg <= unit_last;
                        keep_reg <= keep_last_val;
                        if (unit_zeros != '0) begin
                            state <= decomp_pkg::EXP_ZEROS;
                        end else if (!unit_last || keep_last_val) begin
                            state <= decomp_pkg::EXP_VALUE;
                        end else begin
                            state <= decomp_pkg::EXP_DONE; // nothing left to emit
                        end
                    end
                end
                decomp_pkg::EXP_ZEROS: begin
                    if (elem_ready) begin
                        zero_cnt <= zero_cnt - 1'b1;
                        if (zero_cnt == decomp_pkg::zero_run_t'(1)) begin
                            state <= emit_val ? decomp_pkg::EXP_VALUE : decomp_pkg::EXP_DONE;
                        end
                    end
                end
                decomp_pkg::EXP_VALUE: begin
                    if (elem_ready) begin
                        state <= last_reg ? decomp_pkg::EXP_DONE : decomp_pkg::EXP_IDLE;
                    end
                end
                decomp_pkg::EXP_DONE: state <= decomp_pkg::EXP_DONE; // map finished, wait for start
                default: state <= decomp_pkg::EXP_IDLE;
            endcase
        end
    end

    always_ff @(posedge layer23_gated_clk) begin
        if (unit_take) begin
            val_reg <= unit_val;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/unit_unpacker.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "decomp_defs.svh"

module unit_unpacker (
    input  wire logic               layer23_gated_clk,
    input  wire logic               rst_n,
    input  wire logic               start,
    input  wire logic               group_avail,
    input  wire decomp_pkg::group_t group,
    input  wire logic               unit_take,     // expander consumed the current unit
    output logic                    group_pop,
    output logic                    unit_avail,
    output decomp_pkg::unit_t       unit,
    output logic                    unit_last,     // this unit closes the map
    output logic                    keep_last_val  // end flag of the held group
);

    decomp_pkg::group_t    cur_group;
    decomp_pkg::unit_idx_t unit_idx;
    decomp_pkg::unit_idx_t end_idx;
    decomp_pkg::unit_idx_t last_idx;
    logic                  loaded;     // held group still has units left
    logic                  end_group;
    logic                  at_last;

    assign end_idx   = cur_group[`DECOMP_END_IDX_LSB +: $bits(decomp_pkg::unit_idx_t)];
    assign end_group = (end_idx != `DECOMP_END_IDX_NONE);

    // a normal group runs through unit 4, the end group stops at its end index
    assign last_idx = end_group ? end_idx :
                      decomp_pkg::unit_idx_t'(`DECOMP_UNITS_PER_GROUP - 1);
    assign at_last  = (unit_idx == last_idx);

    // fetch the next group only once the held one is used up
    assign group_pop     = group_avail & ~loaded & ~start;
    assign unit_avail    = loaded;
    assign unit          = cur_group[unit_idx*`DECOMP_UNIT_W +: `DECOMP_UNIT_W];
    assign unit_last     = loaded & end_group & at_last;
    assign keep_last_val = cur_group[`DECOMP_END_FLAG_BIT];

    always_ff @(posedge layer23_gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            loaded   <= 1'b0;
            unit_idx <= '0;
        end else if (start) begin
            loaded   <= 1'b0;
            unit_idx <= '0;
        end else if (group_pop) begin
            loaded   <= 1'b1;      // unit 0 is offered on the next cycle
            unit_idx <= '0;
        end else if (unit_take && loaded) begin
            if (at_last) begin
                loaded <= 1'b0;    // units past the end index are never offered
            end else begin
                unit_idx <= unit_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge layer23_gated_clk) begin
        if (group_pop) begin
            cur_group <= group;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/group_fetch_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "decomp_defs.svh"

module group_fetch_buffer (
    input  wire logic               layer23_gated_clk,
    input  wire logic               rst_n,
    input  wire logic               start,          // controller pulse, restarts the map
    input  wire logic               mem_ack,        // grant in the same cycle as mem_req
    input  wire logic               mem_data_valid,
    input  wire decomp_pkg::group_t mem_data,
    input  wire logic               group_pop,      // unpacker has taken the head group
    output logic                    mem_req,
    output logic                    group_avail,
    output decomp_pkg::group_t      group
);

    localparam int IDX_W = $clog2(`DECOMP_FIFO_DEPTH);

    decomp_pkg::group_t    fifo_mem [`DECOMP_FIFO_DEPTH];
    decomp_pkg::fifo_ptr_t fetch_ptr;   // counts granted requests
    decomp_pkg::fifo_ptr_t wr_ptr;      // counts returned and stored groups
    decomp_pkg::fifo_ptr_t rd_ptr;      // counts groups handed to the unpacker
    logic                  active;      // set by start, keeps fetching legal
    logic                  stop_fetch;  // end group already stored
    logic                  credit_full;
    logic                  wr_en;
    logic                  end_in_word;

    // every granted request owns a slot until it is popped, so the credit
    // is measured between fetch and read pointers and not the write pointer
    assign credit_full = (fetch_ptr[IDX_W] != rd_ptr[IDX_W]) &&
                         (fetch_ptr[IDX_W-1:0] == rd_ptr[IDX_W-1:0]);

    assign mem_req = active & ~stop_fetch & ~credit_full;

    // words coming back after the end group are dropped here
    assign wr_en = mem_data_valid & active & ~stop_fetch;

    // the end index field is 7 unless this word closes the map
    assign end_in_word =
        mem_data[`DECOMP_END_IDX_LSB +: $bits(decomp_pkg::unit_idx_t)] != `DECOMP_END_IDX_NONE;

    always_ff @(posedge layer23_gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            active     <= 1'b0;
            stop_fetch <= 1'b0;
            fetch_ptr  <= '0;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
        end else if (start) begin
            active     <= 1'b1;   // mem_req can rise on the next cycle
            stop_fetch <= 1'b0;
            fetch_ptr  <= '0;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
        end else begin
            if (mem_req && mem_ack) begin
                fetch_ptr <= fetch_ptr + 1'b1;
            end
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
                if (end_in_word) begin
                    stop_fetch <= 1'b1; // mem_req drops from the next cycle
                end
            end
            if (group_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // group storage, written in return order
    always_ff @(posedge layer23_gated_clk) begin
        if (wr_en && !start) begin
            fifo_mem[wr_ptr[IDX_W-1:0]] <= mem_data;
        end
    end

    assign group_avail = (rd_ptr != wr_ptr);         // stored but not yet popped
    assign group       = fifo_mem[rd_ptr[IDX_W-1:0]];

endmodule

`default_nettype wire

// ==== rtl/decomp_pkg.sv ====
`default_nettype none

`include "decomp_defs.svh"

package decomp_pkg;

    typedef logic [`DECOMP_GROUP_W-1:0] group_t;      // memory word / compress group
    typedef logic [`DECOMP_UNIT_W-1:0]  unit_t;       // {value, zero count}
    typedef logic [`DECOMP_ZERO_W-1:0]  zero_run_t;
    typedef logic [`DECOMP_ELEM_W-1:0]  elem_t;       // one decompressed byte
    typedef logic [$clog2(`DECOMP_UNITS_PER_GROUP)-1:0] unit_idx_t;
    typedef logic [$clog2(`DECOMP_FIFO_DEPTH):0] fifo_ptr_t; // msb is the wrap bit
    typedef logic [`DECOMP_PKT_SLOTS*`DECOMP_ELEM_W-1:0] pkt_data_t; // slot 0 in the low byte
    typedef logic [`DECOMP_PKT_SLOTS-1:0] pkt_mask_t;

    // expander walks zero run first, then the value byte
    typedef enum logic [1:0] {
        EXP_IDLE,
        EXP_ZEROS,
        EXP_VALUE,
        EXP_DONE
    } expand_state_t;

endpackage

`default_nettype wire

// ==== rtl/decomp_defs.svh ====
`ifndef DECOMP_DEFS_SVH
`define DECOMP_DEFS_SVH

// one memory word carries exactly one compress group
`define DECOMP_GROUP_W          64
`define DECOMP_UNITS_PER_GROUP  5
`define DECOMP_UNIT_W           12
`define DECOMP_ZERO_W           4   // zero-run count sits in the low bits of a unit
`define DECOMP_ELEM_W           8   // value field and output element share this width

// info bits in the top nibble of a group
`define DECOMP_END_IDX_LSB      60
`define DECOMP_END_FLAG_BIT     63
`define DECOMP_END_IDX_NONE     3'd7 // all five units valid, the map goes on

`define DECOMP_PKT_SLOTS        8
`define DECOMP_FIFO_DEPTH       16

`endif
